// File: source/dps_defines.svh
`ifndef DPS_DEFINES_SVH
`define DPS_DEFINES_SVH

// bus addresses with sensor n at base + n
`define SENSOR_COUNT 2
`define SENSOR_ADDR_BASE 7'h76

// clock dividers
`define I2C_QUARTER_CYCLES 4 // clocks per quarter scl period
`define UART_BIT_CYCLES 8 // 434 on the board

// data widths
`define PRESSURE_BITS 24
`define READ_BYTES_MAX 3

`endif

// File: source/sensor_pkg.sv
package sensor_pkg;

	// DPS310 register map, only what is touched here
	typedef enum logic [7:0] {
		PSR_B2   = 8'h00,
		PRS_CFG  = 8'h06,
		TMP_CFG  = 8'h07,
		MEAS_CFG = 8'h08
	} dps_reg_e;

	typedef enum logic [2:0] {
		SEQ_IDLE,
		SEQ_CONFIG,
		SEQ_WAIT_CONFIG,
		SEQ_READ,
		SEQ_WAIT_READ,
		SEQ_REPORT
	} seq_state_e;

	typedef struct packed {
		dps_reg_e   reg_addr;
		logic [7:0] value;
	} sensor_cmd_t;

	localparam int CONFIG_STEPS = 3;

	localparam sensor_cmd_t CONFIG_TABLE [CONFIG_STEPS] = '{
		'{reg_addr: PRS_CFG, value: 8'h70}, // max rate, single sample
		'{reg_addr: TMP_CFG, value: 8'h07},
		'{reg_addr: MEAS_CFG, value: 8'h07} // continuous pressure and temperature
	};

endpackage

// File: source/bus_pkg.sv
`include "dps_defines.svh"

package bus_pkg;

	typedef struct packed {
		logic       valid;
		logic       read;
		logic [6:0] addr;
		logic [7:0] reg_addr;
		logic [7:0] wdata;
		logic [1:0] count; // bytes to read
	} i2c_req_t;

	typedef struct packed {
		logic                         done;
		logic [`READ_BYTES_MAX*8-1:0] data; // first byte highest
	} i2c_rsp_t;

	typedef enum logic [2:0] {
		PH_IDLE,
		PH_START,
		PH_SHIFT,
		PH_ACK,
		PH_RESTART,
		PH_STOP
	} i2c_phase_e;

	typedef struct packed {
		logic                      valid;
		logic                      sensor;
		logic [`PRESSURE_BITS-1:0] pressure;
	} report_t;

	typedef enum logic [1:0] {
		UART_IDLE,
		UART_START_BIT,
		UART_DATA,
		UART_STOP_BIT
	} uart_state_e;

endpackage

// File: source/sensor_sequencer.sv
`timescale 1ns/1ps
`include "dps_defines.svh"

module sensor_sequencer import sensor_pkg::*, bus_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	input  logic     update,
	output logic     busy,
	output i2c_req_t i2c_req,
	input  logic     i2c_ready,
	input  i2c_rsp_t i2c_rsp,
	output report_t  report,
	input  logic     report_ready
);
	localparam int IDX_W = $clog2(`SENSOR_COUNT);
	localparam logic [IDX_W-1:0] LAST_SENSOR = IDX_W'(`SENSOR_COUNT - 1);
	localparam logic [1:0] LAST_STEP = 2'(CONFIG_STEPS - 1);

	seq_state_e state;
	logic [1:0] step;
	logic [IDX_W-1:0] sensor;
	logic [`PRESSURE_BITS-1:0] pressure;
	sensor_cmd_t cmd;

	assign cmd = CONFIG_TABLE[step];

	// request follows state, stays put until the master takes it
	always_comb begin
		i2c_req.valid = (state == SEQ_CONFIG) || (state == SEQ_READ && report_ready);
		i2c_req.read = (state == SEQ_READ);
		i2c_req.addr = `SENSOR_ADDR_BASE + 7'(sensor);
		i2c_req.reg_addr = (state == SEQ_READ) ? PSR_B2 : cmd.reg_addr;
		i2c_req.wdata = cmd.value;
		i2c_req.count = 2'(`READ_BYTES_MAX);
	end

	assign report = '{valid: (state == SEQ_REPORT), sensor: sensor, pressure: pressure};

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= SEQ_IDLE;
			busy <= 1'b0;
			step <= 2'd0;
			sensor <= '0;
		end else begin
			case (state)
				SEQ_IDLE: begin
					if (!busy && update) begin
						busy <= 1'b1;
						step <= 2'd0;
						sensor <= '0;
						state <= SEQ_CONFIG;
					end else if (busy && report_ready) begin
						busy <= 1'b0; // last frame has left the wire
					end
				end
				SEQ_CONFIG: begin
					if (i2c_ready)
						state <= SEQ_WAIT_CONFIG;
				end
				SEQ_WAIT_CONFIG: begin
					if (i2c_rsp.done) begin
						state <= SEQ_CONFIG;
						if (sensor == LAST_SENSOR) begin
							sensor <= '0;
							if (step == LAST_STEP)
								state <= SEQ_READ;
							else
								step <= step + 2'd1;
						end else begin
							sensor <= sensor + 1'b1;
						end
					end
				end
				SEQ_READ: begin
					if (i2c_ready && report_ready)
						state <= SEQ_WAIT_READ;
				end
				SEQ_WAIT_READ: begin
					if (i2c_rsp.done)
						state <= SEQ_REPORT;
				end
				SEQ_REPORT: begin
					if (report_ready) begin
						if (sensor == LAST_SENSOR) begin
							sensor <= '0;
							state <= SEQ_IDLE;
						end else begin
							sensor <= sensor + 1'b1;
							state <= SEQ_READ;
						end
					end
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == SEQ_WAIT_READ && i2c_rsp.done)
			pressure <= i2c_rsp.data;
	end

endmodule

// File: source/i2c_master.sv
`timescale 1ns/1ps
`include "dps_defines.svh"

module i2c_master import bus_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	input  i2c_req_t req,
	output logic     ready,
	output i2c_rsp_t rsp,
	output logic     scl,
	output logic     sda_low,
	input  logic     sda_in
);
	localparam int QC = `I2C_QUARTER_CYCLES;
	localparam int DIV_W = $clog2(QC + 1);

	i2c_phase_e phase;
	i2c_req_t cur;
	logic [DIV_W-1:0] div;
	logic tick;
	logic [1:0] quarter;
	logic [2:0] bit_idx;
	logic [2:0] byte_idx;
	logic [2:0] last_byte;
	logic rx_byte;
	logic [7:0] tx_byte;
	logic done;
	logic [`READ_BYTES_MAX*8-1:0] rx_data;
	logic scl_next;
	logic sda_low_next;

	assign ready = (phase == PH_IDLE);
	assign tick = (div == DIV_W'(QC - 1));
	// byte 0 address, 1 register, then data or address again plus read bytes
	assign last_byte = cur.read ? 3'd2 + 3'(cur.count) : 3'd2;
	assign rx_byte = cur.read && (byte_idx > 3'd2);
	assign rsp = '{done: done, data: rx_data};

	always_comb begin
		case (byte_idx)
			3'd0: tx_byte = {cur.addr, 1'b0};
			3'd1: tx_byte = cur.reg_addr;
			3'd2: tx_byte = cur.read ? {cur.addr, 1'b1} : cur.wdata;
			default: tx_byte = 8'hff;
		endcase
	end

	// scl high in the middle two quarters of a bit
	always_comb begin
		scl_next = quarter[0] ^ quarter[1];
		sda_low_next = 1'b0;
		case (phase)
			PH_IDLE: scl_next = 1'b1;
			PH_START: begin
				scl_next = (quarter != 2'd3);
				sda_low_next = quarter[1]; // falls while scl high
			end
			PH_RESTART: sda_low_next = quarter[1];
			PH_SHIFT: sda_low_next = !rx_byte && !tx_byte[bit_idx];
			PH_ACK: sda_low_next = rx_byte && (byte_idx != last_byte); // nack on last
			PH_STOP: begin
				scl_next = (quarter != 2'd0);
				sda_low_next = !quarter[1];
			end
			default: ;
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			phase <= PH_IDLE;
			div <= '0;
			quarter <= 2'd0;
			bit_idx <= 3'd0;
			byte_idx <= 3'd0;
			done <= 1'b0;
			scl <= 1'b1;
			sda_low <= 1'b0;
		end else begin
			scl <= scl_next;
			sda_low <= sda_low_next;
			done <= 1'b0;
			if (phase == PH_IDLE) begin
				div <= '0;
				quarter <= 2'd0;
				byte_idx <= 3'd0;
				if (req.valid)
					phase <= PH_START;
			end else begin
				div <= tick ? '0 : div + 1'b1;
				if (tick) begin
					quarter <= quarter + 2'd1;
					if (quarter == 2'd3) begin
						case (phase)
							PH_START, PH_RESTART: begin
								phase <= PH_SHIFT;
								bit_idx <= 3'd7;
							end
							PH_SHIFT: begin
								if (bit_idx == 3'd0)
									phase <= PH_ACK;
								else
									bit_idx <= bit_idx - 3'd1;
							end
							PH_ACK: begin
								byte_idx <= byte_idx + 3'd1;
								bit_idx <= 3'd7;
								if (byte_idx == last_byte)
									phase <= PH_STOP;
								else if (cur.read && byte_idx == 3'd1)
									phase <= PH_RESTART;
								else
									phase <= PH_SHIFT;
							end
							PH_STOP: begin
								phase <= PH_IDLE;
								done <= 1'b1;
							end
							default: phase <= PH_IDLE;
						endcase
					end
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (phase == PH_IDLE && req.valid) begin
			cur <= req;
			rx_data <= '0;
		end else if (phase == PH_SHIFT && rx_byte && tick && quarter == 2'd1) begin
			rx_data <= {rx_data[$bits(rx_data)-2:0], sda_in}; // sample mid scl high
		end
	end

endmodule

// File: source/uart_reporter.sv
`timescale 1ns/1ps
`include "dps_defines.svh"

module uart_reporter import bus_pkg::*; (
	input  logic    clock,
	input  logic    reset,
	input  report_t report,
	output logic    ready,
	output logic    uart_out
);
	localparam int BIT_CYCLES = `UART_BIT_CYCLES;
	localparam int BAUD_W = $clog2(BIT_CYCLES + 1);
	localparam int FRAME_BITS = 8 + `PRESSURE_BITS;
	localparam logic [1:0] LAST_BYTE = 2'(FRAME_BITS / 8 - 1);

	uart_state_e state;
	logic [BAUD_W-1:0] baud;
	logic bit_end;
	logic [2:0] bit_cnt;
	logic [1:0] byte_cnt;
	logic [FRAME_BITS-1:0] frame;
	logic [7:0] cur_byte;

	assign ready = (state == UART_IDLE);
	assign bit_end = (baud == BAUD_W'(BIT_CYCLES - 1));
	assign cur_byte = frame[FRAME_BITS-1 -: 8];

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= UART_IDLE;
			baud <= '0;
			bit_cnt <= 3'd0;
			byte_cnt <= 2'd0;
			uart_out <= 1'b1;
		end else begin
			if (state != UART_IDLE)
				baud <= bit_end ? '0 : baud + 1'b1;
			case (state)
				UART_IDLE: begin
					baud <= '0;
					if (report.valid) begin
						state <= UART_START_BIT;
						byte_cnt <= 2'd0;
						uart_out <= 1'b0;
					end
				end
				UART_START_BIT: begin
					if (bit_end) begin
						state <= UART_DATA;
						bit_cnt <= 3'd0;
						uart_out <= cur_byte[0]; // lsb first on the wire
					end
				end
				UART_DATA: begin
					if (bit_end) begin
						if (bit_cnt == 3'd7) begin
							state <= UART_STOP_BIT;
							uart_out <= 1'b1;
						end else begin
							bit_cnt <= bit_cnt + 3'd1;
							uart_out <= cur_byte[bit_cnt + 3'd1];
						end
					end
				end
				UART_STOP_BIT: begin
					if (bit_end) begin
						if (byte_cnt == LAST_BYTE) begin
							state <= UART_IDLE;
						end else begin
							byte_cnt <= byte_cnt + 2'd1;
							state <= UART_START_BIT;
							uart_out <= 1'b0;
						end
					end
				end
				default: state <= UART_IDLE;
			endcase
		end
	end

	// index byte first, then pressure high byte first
	always_ff @(posedge clock) begin
		if (state == UART_IDLE && report.valid)
			frame <= {7'd0, report.sensor, report.pressure};
		else if (state == UART_STOP_BIT && bit_end)
			frame <= frame << 8;
	end

endmodule

// File: source/dps_pair_top.sv
`timescale 1ns/1ps

module dps_pair_top import bus_pkg::*; (
	input  logic clock,
	input  logic reset,
	input  logic update,
	inout  wire  sda,
	output logic scl,
	output logic uart_out,
	output logic busy
);
	i2c_req_t i2c_req;
	i2c_rsp_t i2c_rsp;
	logic i2c_ready;
	report_t report;
	logic report_ready;
	logic sda_low;

	assign sda = sda_low ? 1'b0 : 1'bz; // open drain with the pullup outside

	sensor_sequencer u_sequencer (
		.clock(clock),
		.reset(reset),
		.update(update),
		.busy(busy),
		.i2c_req(i2c_req),
		.i2c_ready(i2c_ready),
		.i2c_rsp(i2c_rsp),
		.report(report),
		.report_ready(report_ready)
	);

	i2c_master u_i2c (
		.clock(clock),
		.reset(reset),
		.req(i2c_req),
		.ready(i2c_ready),
		.rsp(i2c_rsp),
		.scl(scl),
		.sda_low(sda_low),
		.sda_in(sda)
	);

	uart_reporter u_uart (
		.clock(clock),
		.reset(reset),
		.report(report),
		.ready(report_ready),
		.uart_out(uart_out)
	);

endmodule

// File: dv/dps_sensor_model.sv
`timescale 1ns/1ps
`include "dps_defines.svh"

module dps_sensor_model (
	input  logic        scl,
	inout  wire         sda,
	input  logic [47:0] values // sensor 1 high half, sensor 0 low half
);
	logic [23:0] write_log [$]; // {addr, reg, value}
	logic [15:0] read_log [$];  // {addr, reg pointer}

	logic [7:0] shreg = 8'h00;
	logic [6:0] addr = 7'h00;
	logic [7:0] reg_ptr = 8'h00;
	logic [23:0] txd = 24'h0;
	logic rd = 1'b0;
	logic drive_low = 1'b0;
	int bit_n = 0;
	int byte_n = 0;

	assign sda = drive_low ? 1'b0 : 1'bz;

	// start or repeated start
	always @(negedge sda) begin
		if (scl === 1'b1) begin
			bit_n = 0;
			byte_n = 0;
			rd = 1'b0;
		end
	end

	always @(posedge scl) begin
		if (bit_n < 8) begin
			shreg = {shreg[6:0], sda === 1'b0 ? 1'b0 : 1'b1};
			if (rd)
				txd = txd << 1;
		end
		bit_n++;
		if (bit_n == 9) begin // ack slot done
			bit_n = 0;
			if (!rd) begin
				if (byte_n == 0) begin
					addr = shreg[7:1];
					rd = shreg[0];
					if (rd) begin
						txd = (addr == `SENSOR_ADDR_BASE) ? values[23:0] : values[47:24];
						read_log.push_back({1'b0, addr, reg_ptr});
					end
				end else if (byte_n == 1) begin
					reg_ptr = shreg;
				end else if (byte_n == 2) begin
					write_log.push_back({1'b0, addr, reg_ptr, shreg});
				end
			end
			byte_n++;
		end
	end

	// data changes while scl is low
	always @(negedge scl) begin
		drive_low = rd && bit_n < 8 && byte_n <= 3 && !txd[23];
	end

endmodule

// File: dv/dps_pair_assert.sv
`timescale 1ns/1ps

module dps_pair_assert import bus_pkg::*; (
	input logic     clock,
	input logic     reset,
	input logic     busy,
	input logic     scl,
	input logic     sda,
	input logic     uart_out,
	input i2c_req_t i2c_req,
	input logic     i2c_ready,
	input i2c_rsp_t i2c_rsp,
	input report_t  report,
	input logic     report_ready
);
	// async reset has acted by the next edge
	reset_idle: assert property (@(posedge clock)
		reset |=> !busy && scl && sda && uart_out)
		else $error("outputs not idle during reset");

	req_taken: assert property (@(posedge clock) disable iff (reset)
		i2c_req.valid && i2c_ready |=> !i2c_ready)
		else $error("i2c master still ready after taking a request");

	ready_with_done: assert property (@(posedge clock) disable iff (reset)
		$rose(i2c_ready) |-> i2c_rsp.done)
		else $error("i2c master ready again without a done pulse");

	done_pulse: assert property (@(posedge clock) disable iff (reset)
		i2c_rsp.done |=> !i2c_rsp.done)
		else $error("done pulse longer than one cycle");

	report_taken: assert property (@(posedge clock) disable iff (reset)
		report.valid && report_ready |=> !report_ready)
		else $error("reporter still ready after taking a report");

	uart_idle_high: assert property (@(posedge clock) disable iff (reset)
		report_ready |-> uart_out)
		else $error("uart line low while reporter idle");

	bus_idle_high: assert property (@(posedge clock) disable iff (reset)
		i2c_ready |-> scl && sda)
		else $error("i2c bus not released while master idle");

endmodule

bind dps_pair_top dps_pair_assert assert_inst (
	.clock(clock),
	.reset(reset),
	.busy(busy),
	.scl(scl),
	.sda(sda),
	.uart_out(uart_out),
	.i2c_req(i2c_req),
	.i2c_ready(i2c_ready),
	.i2c_rsp(i2c_rsp),
	.report(report),
	.report_ready(report_ready)
);

// File: dv/dps_pair_tb.sv
`timescale 1ns/1ps
`include "dps_defines.svh"

module dps_pair_tb;
	localparam int BIT_NS = `UART_BIT_CYCLES * 10;
	localparam int WRITE_Q = 4 + 3 * 36 + 4; // quarters per register write
	localparam int READ_Q = 4 + 2 * 36 + 4 + (1 + `READ_BYTES_MAX) * 36 + 4;
	localparam int RUN_CYCLES = (3 * `SENSOR_COUNT * WRITE_Q + `SENSOR_COUNT * READ_Q)
		* `I2C_QUARTER_CYCLES + `SENSOR_COUNT * 40 * `UART_BIT_CYCLES + 100;
	localparam int TIMEOUT = 2 * 3 * RUN_CYCLES + 500;
	localparam logic [15:0] CONFIG_WRITES [3] = '{16'h0670, 16'h0707, 16'h0807};

	logic clock = 1'b0;
	logic reset = 1'b1;
	logic update = 1'b0;
	logic [47:0] values = 48'h0;
	wire sda;
	logic scl;
	logic uart_out;
	logic busy;
	logic [7:0] rx_bytes [$];
	int cycle_count = 0;

	pullup (sda);

	always #5 clock = ~clock;

	dps_pair_top dps_pair_top_inst (.clock(clock), .reset(reset), .update(update), .sda(sda),
		.scl(scl), .uart_out(uart_out), .busy(busy));

	dps_sensor_model sensor_model (.scl(scl), .sda(sda), .values(values));

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic expect_equal(input logic [31:0] got, input logic [31:0] want,
		input string what);
		assert (got === want)
			else fail_run($sformatf("MISMATCH at %0t: %s got %0h expected %0h",
				$time, what, got, want));
	endtask

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT)
			fail_run("timeout, run did not finish");
	end

	// uart receiver sampling mid bit
	always begin
		logic [7:0] b;
		@(negedge uart_out);
		#(BIT_NS / 2);
		for (int i = 0; i < 8; i++) begin
			#(BIT_NS);
			b[i] = uart_out;
		end
		#(BIT_NS);
		if (uart_out !== 1'b1)
			fail_run("uart stop bit missing");
		rx_bytes.push_back(b);
	end

	task automatic measure_run(input int run);
		logic [23:0] p [2];
		int s;
		p[0] = 24'($urandom());
		p[1] = 24'($urandom());
		values = {p[1], p[0]};
		sensor_model.write_log.delete();
		sensor_model.read_log.delete();
		rx_bytes.delete();
		@(negedge clock);
		update = 1'b1;
		@(negedge clock);
		update = 1'b0;
		wait (busy);
		repeat (50) @(negedge clock);
		update = 1'b1; // must be ignored
		@(negedge clock);
		update = 1'b0;
		wait (!busy);
		// last stop bit already sampled when busy drops
		expect_equal(rx_bytes.size(), 8,
			$sformatf("run %0d bytes received when busy fell", run));
		repeat (20) @(negedge clock);
		expect_equal(sensor_model.write_log.size(), 6, "write count");
		for (int k = 0; k < 6; k++)
			expect_equal(sensor_model.write_log[k],
				{1'b0, 7'(`SENSOR_ADDR_BASE + k % 2), CONFIG_WRITES[k / 2]}, "config write");
		expect_equal(sensor_model.read_log.size(), 2, "read count");
		expect_equal(rx_bytes.size(), 8, "uart byte count");
		for (s = 0; s < 2; s++) begin
			expect_equal(sensor_model.read_log[s], {1'b0, 7'(`SENSOR_ADDR_BASE + s), 8'h00},
				"pressure read target");
			expect_equal(rx_bytes[4 * s], s, "frame sensor index");
			expect_equal(rx_bytes[4 * s + 1], p[s][23:16], "pressure high byte");
			expect_equal(rx_bytes[4 * s + 2], p[s][15:8], "pressure middle byte");
			expect_equal(rx_bytes[4 * s + 3], p[s][7:0], "pressure low byte");
		end
	endtask

	initial begin
		void'($urandom(52482));
		repeat (16) @(negedge clock);
		reset = 1'b0;
		repeat (4) @(negedge clock);
		expect_equal({scl, sda, uart_out, busy}, 4'b1110, "idle outputs after reset");
		for (int r = 0; r < 3; r++)
			measure_run(r);
		$display("all tests passed");
		$finish;
	end

endmodule

// File: sources.f
+incdir+source
source/sensor_pkg.sv
source/bus_pkg.sv
source/sensor_sequencer.sv
source/i2c_master.sv
source/uart_reporter.sv
source/dps_pair_top.sv
dv/dps_sensor_model.sv
dv/dps_pair_assert.sv
dv/dps_pair_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module dps_pair_tb -o dps_pair_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/dps_pair_sim
if [ $? -ne 0 ]; then
	echo "simulation failed"
	exit 1
fi
exit 0
